//--- design/oflow_pkg.sv
// shared widths, feature struct and FSM state enum for the score stage

package oflow_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	// object id, 0 marks an empty slot
	localparam int ID_LEN = 4;

	// one feature field
	localparam int FEAT_W = 8;

	// sum of four feature differences
	// 4 * 255 = 1020 fits in FEAT_W + 2 bits
	localparam int SCORE_W = FEAT_W + 2;

	// ------------------------------
	// types
	// ------------------------------

	// object features, 32 bits packed
	typedef struct packed {
		logic [FEAT_W-1:0] x;
		logic [FEAT_W-1:0] y;
		logic [FEAT_W-1:0] w;
		logic [FEAT_W-1:0] h;
	} oflow_feature_t;

	// score calc control states
	typedef enum logic [1:0] {
		idle_st,
		similarity_metric_st,
		wait_st
	} oflow_score_fsm_t;

endpackage

//--- design/oflow_sm_if.sv
// similarity metric lane interface and its modports
`timescale 1ns/1ps

interface oflow_sm_if import oflow_pkg::*; ();

	// start strobe from the control FSM
	logic start;

	// stored object at the current pair pointer
	logic [ID_LEN-1:0] id;
	oflow_feature_t stored;

	// lane result, valid with done
	logic done;
	logic [SCORE_W-1:0] score;
	logic [ID_LEN-1:0] score_id;

	// object table side
	modport buf_mp (
		input  start,
		output id,
		output stored
	);

	// control FSM side
	modport fsm_mp (
		output start,
		input  id,
		input  done
	);

	// metric unit side
	modport metric_mp (
		input  start,
		input  id,
		input  stored,
		output done,
		output score,
		output score_id
	);

	// best match select side
	modport sel_mp (
		input done,
		input score,
		input score_id
	);

endinterface

//--- design/oflow_score_buffer.sv
// object table with write port, pair read pointer and done_read strobe
`timescale 1ns/1ps

module oflow_score_buffer import oflow_pkg::*; #(
	parameter int NUM_OBJ = 8
) (
	input  logic clk,
	input  logic reset_N,
	input  logic start_score_calc,
	input  logic wr_en,
	input  logic [$clog2(NUM_OBJ)-1:0] wr_addr,
	input  logic [ID_LEN-1:0] wr_id,
	input  oflow_feature_t wr_feat,
	oflow_sm_if.buf_mp lane_0,
	oflow_sm_if.buf_mp lane_1,
	output logic done_read
);

	// ------------------------------
	// locals
	// ------------------------------

	localparam int NUM_PAIRS = NUM_OBJ / 2;
	localparam int PTR_W = (NUM_PAIRS > 1) ? $clog2(NUM_PAIRS) : 1;

	// table storage
	logic [ID_LEN-1:0] slot_id [NUM_OBJ];
	oflow_feature_t slot_feat [NUM_OBJ];

	// pair pointer and run tracking
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] cur_ptr;
	logic busy;
	logic last_pair;

	// ------------------------------
	// table writes
	// ------------------------------

	// ids cleared so an unwritten slot reads as empty
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < NUM_OBJ; i++) begin
				slot_id[i] <= '0;
			end
		end else if (wr_en) begin
			slot_id[wr_addr] <= wr_id;
		end
	end

	// feature payload
	always_ff @(posedge clk) begin
		if (wr_en) begin
			slot_feat[wr_addr] <= wr_feat;
		end
	end

	// ------------------------------
	// pair pointer
	// ------------------------------

	// a start outside a run points back at pair 0
	assign cur_ptr = (start_score_calc && !busy) ? '0 : rd_ptr;
	assign last_pair = (cur_ptr == PTR_W'(NUM_PAIRS - 1));

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rd_ptr <= '0;
			busy <= 1'b0;
			done_read <= 1'b0;
		end else begin
			done_read <= 1'b0;
			if (lane_0.start) begin
				if (last_pair) begin
					// final pair issued, wrap for the next run
					rd_ptr <= '0;
					busy <= 1'b0;
					done_read <= 1'b1;
				end else begin
					rd_ptr <= cur_ptr + 1'b1;
					busy <= 1'b1;
				end
			end else if (start_score_calc && !busy) begin
				rd_ptr <= '0;
			end
		end
	end

	// ------------------------------
	// lane read out
	// ------------------------------

	// even slot on lane 0, odd slot on lane 1
	assign lane_0.id = slot_id[{cur_ptr, 1'b0}];
	assign lane_0.stored = slot_feat[{cur_ptr, 1'b0}];
	assign lane_1.id = slot_id[{cur_ptr, 1'b1}];
	assign lane_1.stored = slot_feat[{cur_ptr, 1'b1}];

endmodule

//--- design/oflow_score_calc_fsm.sv
// control FSM that sequences both metric lanes over all table pairs
`timescale 1ns/1ps

module oflow_score_calc_fsm import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  logic start_score_calc,
	input  logic done_read,
	oflow_sm_if.fsm_mp lane_0,
	oflow_sm_if.fsm_mp lane_1,
	output logic done_score_calc
);

	// ------------------------------
	// locals
	// ------------------------------

	oflow_score_fsm_t cur_st;
	oflow_score_fsm_t nxt_st;

	// set once the buffer has issued the final pair
	logic last;

	// one pair launch this cycle
	logic start_pair;

	// ------------------------------
	// state register
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cur_st <= idle_st;
		end else begin
			cur_st <= nxt_st;
		end
	end

	// ------------------------------
	// last pair flag
	// ------------------------------

	// cleared by the done of the final pair
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			last <= 1'b0;
		end else if (done_read) begin
			last <= 1'b1;
		end else if (lane_0.done && last) begin
			last <= 1'b0;
		end
	end

	// ------------------------------
	// next state and strobes
	// ------------------------------

	always_comb begin
		nxt_st = cur_st;
		start_pair = 1'b0;
		done_score_calc = 1'b0;
		case (cur_st)
			idle_st: begin
				// starts elsewhere in the run are ignored
				if (start_score_calc) begin
					start_pair = 1'b1;
					nxt_st = similarity_metric_st;
				end
			end
			similarity_metric_st: begin
				// metric stage 1 busy
				nxt_st = wait_st;
			end
			wait_st: begin
				if (lane_0.done && !last) begin
					start_pair = 1'b1;
					nxt_st = similarity_metric_st;
				end else if (lane_0.done && last) begin
					done_score_calc = 1'b1;
					nxt_st = idle_st;
				end
			end
			default: begin
				nxt_st = idle_st;
			end
		endcase
	end

	// lane 0 always runs, lane 1 skips an empty odd slot
	assign lane_0.start = start_pair;
	assign lane_1.start = start_pair && (lane_1.id != '0);

endmodule

//--- design/oflow_similarity_metric.sv
// two-stage sum of absolute differences, one unit per lane
`timescale 1ns/1ps

module oflow_similarity_metric import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  oflow_feature_t cur_feat,
	oflow_sm_if.metric_mp lane
);

	// ------------------------------
	// locals
	// ------------------------------

	// stage 1 per-feature differences
	logic [FEAT_W-1:0] diff_x;
	logic [FEAT_W-1:0] diff_y;
	logic [FEAT_W-1:0] diff_w;
	logic [FEAT_W-1:0] diff_h;
	logic [ID_LEN-1:0] id_s1;
	logic valid_s1;

	// magnitude of a - b
	function automatic logic [FEAT_W-1:0] abs_diff(
		input logic [FEAT_W-1:0] a,
		input logic [FEAT_W-1:0] b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// ------------------------------
	// stage 1
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			valid_s1 <= 1'b0;
		end else begin
			valid_s1 <= lane.start;
		end
	end

	// differences and id captured with the start
	always_ff @(posedge clk) begin
		if (lane.start) begin
			diff_x <= abs_diff(cur_feat.x, lane.stored.x);
			diff_y <= abs_diff(cur_feat.y, lane.stored.y);
			diff_w <= abs_diff(cur_feat.w, lane.stored.w);
			diff_h <= abs_diff(cur_feat.h, lane.stored.h);
			id_s1 <= lane.id;
		end
	end

	// ------------------------------
	// stage 2
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			lane.done <= 1'b0;
		end else begin
			lane.done <= valid_s1;
		end
	end

	// widen before adding, no overflow at SCORE_W
	always_ff @(posedge clk) begin
		if (valid_s1) begin
			lane.score <= SCORE_W'(diff_x) + SCORE_W'(diff_y)
				+ SCORE_W'(diff_w) + SCORE_W'(diff_h);
			lane.score_id <= id_s1;
		end
	end

endmodule

//--- design/oflow_score_select.sv
// running minimum over both lane results and final best match register
`timescale 1ns/1ps

module oflow_score_select import oflow_pkg::*; (
	input  logic clk,
	input  logic reset_N,
	input  logic start_score_calc,
	input  logic done_score_calc,
	oflow_sm_if.sel_mp lane_0,
	oflow_sm_if.sel_mp lane_1,
	output logic result_valid,
	output logic [ID_LEN-1:0] best_id,
	output logic [SCORE_W-1:0] best_score,
	output logic match_found
);

	// ------------------------------
	// locals
	// ------------------------------

	// inside a run, extra starts leave the running best alone
	logic busy;

	// running best so far
	logic [SCORE_W-1:0] run_score;
	logic [ID_LEN-1:0] run_id;

	// after lane 0, after both lanes
	logic [SCORE_W-1:0] mrg0_score;
	logic [ID_LEN-1:0] mrg0_id;
	logic [SCORE_W-1:0] mrg_score;
	logic [ID_LEN-1:0] mrg_id;

	// ------------------------------
	// merge
	// ------------------------------

	// strictly lower wins, so ties keep the lower slot
	always_comb begin
		mrg0_score = run_score;
		mrg0_id = run_id;
		if (lane_0.done && (lane_0.score_id != '0) && (lane_0.score < run_score)) begin
			mrg0_score = lane_0.score;
			mrg0_id = lane_0.score_id;
		end
		mrg_score = mrg0_score;
		mrg_id = mrg0_id;
		if (lane_1.done && (lane_1.score_id != '0) && (lane_1.score < mrg0_score)) begin
			mrg_score = lane_1.score;
			mrg_id = lane_1.score_id;
		end
	end

	// ------------------------------
	// running best
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			run_score <= '1;
			run_id <= '0;
		end else begin
			if (done_score_calc) begin
				busy <= 1'b0;
			end else if (start_score_calc) begin
				busy <= 1'b1;
			end
			if (start_score_calc && !busy) begin
				// no candidate yet
				run_score <= '1;
				run_id <= '0;
			end else begin
				run_score <= mrg_score;
				run_id <= mrg_id;
			end
		end
	end

	// ------------------------------
	// result
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= done_score_calc;
		end
	end

	// final lane results merged in the same cycle
	always_ff @(posedge clk) begin
		if (done_score_calc) begin
			best_id <= mrg_id;
			best_score <= mrg_score;
			match_found <= (mrg_id != '0);
		end
	end

endmodule

//--- design/oflow_score_calc_top.sv
// score calc top level, table, FSM, two metric lanes and best match select
`timescale 1ns/1ps

module oflow_score_calc_top import oflow_pkg::*; #(
	parameter int NUM_OBJ = 8
) (
	input  logic clk,
	input  logic reset_N,
	input  logic start_score_calc,
	// current object
	input  logic [FEAT_W-1:0] cur_x,
	input  logic [FEAT_W-1:0] cur_y,
	input  logic [FEAT_W-1:0] cur_w,
	input  logic [FEAT_W-1:0] cur_h,
	// table write port
	input  logic wr_en,
	input  logic [$clog2(NUM_OBJ)-1:0] wr_addr,
	input  logic [ID_LEN-1:0] wr_id,
	input  logic [FEAT_W-1:0] wr_x,
	input  logic [FEAT_W-1:0] wr_y,
	input  logic [FEAT_W-1:0] wr_w,
	input  logic [FEAT_W-1:0] wr_h,
	// best match
	output logic result_valid,
	output logic [ID_LEN-1:0] best_id,
	output logic [SCORE_W-1:0] best_score,
	output logic match_found
);

	// ------------------------------
	// wires
	// ------------------------------

	oflow_feature_t cur_feat;
	oflow_feature_t wr_feat;
	logic done_read;
	logic done_score_calc;

	// one lane per slot of a pair
	oflow_sm_if lane_0 ();
	oflow_sm_if lane_1 ();

	// pack the feature fields
	assign cur_feat = '{x: cur_x, y: cur_y, w: cur_w, h: cur_h};
	assign wr_feat = '{x: wr_x, y: wr_y, w: wr_w, h: wr_h};

	// ------------------------------
	// instances
	// ------------------------------

	oflow_score_buffer #(
		.NUM_OBJ (NUM_OBJ)
	) buf_i (
		.clk (clk),
		.reset_N (reset_N),
		.start_score_calc (start_score_calc),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_id (wr_id),
		.wr_feat (wr_feat),
		.lane_0 (lane_0),
		.lane_1 (lane_1),
		.done_read (done_read)
	);

	oflow_score_calc_fsm fsm_i (
		.clk (clk),
		.reset_N (reset_N),
		.start_score_calc (start_score_calc),
		.done_read (done_read),
		.lane_0 (lane_0),
		.lane_1 (lane_1),
		.done_score_calc (done_score_calc)
	);

	// even slot lane
	oflow_similarity_metric metric_0_i (
		.clk (clk),
		.reset_N (reset_N),
		.cur_feat (cur_feat),
		.lane (lane_0)
	);

	// odd slot lane
	oflow_similarity_metric metric_1_i (
		.clk (clk),
		.reset_N (reset_N),
		.cur_feat (cur_feat),
		.lane (lane_1)
	);

	oflow_score_select sel_i (
		.clk (clk),
		.reset_N (reset_N),
		.start_score_calc (start_score_calc),
		.done_score_calc (done_score_calc),
		.lane_0 (lane_0),
		.lane_1 (lane_1),
		.result_valid (result_valid),
		.best_id (best_id),
		.best_score (best_score),
		.match_found (match_found)
	);

endmodule

//--- verif/oflow_score_calc_tb.sv
// score calc testbench with clock, reset, stimulus, reference model and assertions
`timescale 1ns/1ps

module oflow_score_calc_tb import oflow_pkg::*; ();

	// ------------------------------
	// constants
	// ------------------------------

	localparam int NUM_OBJ = 8;
	localparam int ADDR_W = $clog2(NUM_OBJ);
	localparam int MAX_SCORE = (1 << SCORE_W) - 1;
	// start sample to result_valid sample
	localparam int LATENCY = NUM_OBJ + 1;
	localparam int TIMEOUT = 200;

	// ------------------------------
	// DUT signals
	// ------------------------------

	logic clk;
	logic reset_N;
	logic start_score_calc;
	logic [FEAT_W-1:0] cur_x;
	logic [FEAT_W-1:0] cur_y;
	logic [FEAT_W-1:0] cur_w;
	logic [FEAT_W-1:0] cur_h;
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [ID_LEN-1:0] wr_id;
	logic [FEAT_W-1:0] wr_x;
	logic [FEAT_W-1:0] wr_y;
	logic [FEAT_W-1:0] wr_w;
	logic [FEAT_W-1:0] wr_h;
	logic result_valid;
	logic [ID_LEN-1:0] best_id;
	logic [SCORE_W-1:0] best_score;
	logic match_found;

	// ------------------------------
	// model state
	// ------------------------------

	int model_id [NUM_OBJ];
	oflow_feature_t model_feat [NUM_OBJ];
	oflow_feature_t model_cur;
	int exp_id;
	int exp_score;
	int exp_match;
	string test_name;

	// run tracking for latency
	logic run_active;
	int cyc_cnt;

	oflow_score_calc_top #(
		.NUM_OBJ (NUM_OBJ)
	) dut_i (
		.clk (clk),
		.reset_N (reset_N),
		.start_score_calc (start_score_calc),
		.cur_x (cur_x),
		.cur_y (cur_y),
		.cur_w (cur_w),
		.cur_h (cur_h),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.wr_id (wr_id),
		.wr_x (wr_x),
		.wr_y (wr_y),
		.wr_w (wr_w),
		.wr_h (wr_h),
		.result_valid (result_valid),
		.best_id (best_id),
		.best_score (best_score),
		.match_found (match_found)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// ------------------------------
	// reporting
	// ------------------------------

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("FAIL %s %s expected %0d actual %0d", test_name, what, expected, actual);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("%s: %s", test_name, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// ------------------------------
	// cycle counter
	// ------------------------------

	// 1 at the edge after the sampled start, so reads LATENCY at result_valid
	always @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			run_active <= 1'b0;
			cyc_cnt <= 0;
		end else if (start_score_calc && !run_active) begin
			run_active <= 1'b1;
			cyc_cnt <= 1;
		end else if (run_active) begin
			cyc_cnt <= cyc_cnt + 1;
			if (result_valid) begin
				run_active <= 1'b0;
			end
		end
	end

	// ------------------------------
	// assertions
	// ------------------------------

	// also covers the quiet time after reset and duplicate strobes
	result_in_run: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> run_active)
		else report_error("result_valid pulsed outside a run");

	result_latency: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> (cyc_cnt == LATENCY))
		else report_mismatch("latency", LATENCY, $sampled(cyc_cnt));

	result_id: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> (best_id == exp_id))
		else report_mismatch("best_id", exp_id, $sampled(best_id));

	result_score: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> (best_score == exp_score))
		else report_mismatch("best_score", exp_score, $sampled(best_score));

	result_match: assert property (@(posedge clk) disable iff (!reset_N)
		result_valid |-> (match_found == exp_match))
		else report_mismatch("match_found", exp_match, $sampled(match_found));

	// ------------------------------
	// reference model
	// ------------------------------

	function automatic int feat_dist(input oflow_feature_t a, input oflow_feature_t b);
		int d;
		d = (a.x > b.x) ? (a.x - b.x) : (b.x - a.x);
		d += (a.y > b.y) ? (a.y - b.y) : (b.y - a.y);
		d += (a.w > b.w) ? (a.w - b.w) : (b.w - a.w);
		d += (a.h > b.h) ? (a.h - b.h) : (b.h - a.h);
		return d;
	endfunction

	// lowest score over used slots, lower slot kept on a tie
	task automatic compute_expected();
		int s;
		exp_id = 0;
		exp_score = MAX_SCORE;
		for (int i = 0; i < NUM_OBJ; i++) begin
			if (model_id[i] != 0) begin
				s = feat_dist(model_cur, model_feat[i]);
				if (s < exp_score) begin
					exp_score = s;
					exp_id = model_id[i];
				end
			end
		end
		exp_match = (exp_id != 0);
	endtask

	// ------------------------------
	// stimulus tasks
	// ------------------------------

	function automatic oflow_feature_t rand_feat();
		oflow_feature_t f;
		f.x = FEAT_W'($urandom_range(0, 255));
		f.y = FEAT_W'($urandom_range(0, 255));
		f.w = FEAT_W'($urandom_range(0, 255));
		f.h = FEAT_W'($urandom_range(0, 255));
		return f;
	endfunction

	// at least 40 away from a mid-range c
	function automatic oflow_feature_t far_feat(input oflow_feature_t c);
		oflow_feature_t f;
		f.x = c.x + FEAT_W'(10 + $urandom_range(0, 40));
		f.y = c.y + FEAT_W'(10 + $urandom_range(0, 40));
		f.w = c.w + FEAT_W'(10 + $urandom_range(0, 40));
		f.h = c.h + FEAT_W'(10 + $urandom_range(0, 40));
		return f;
	endfunction

	task automatic set_current(input oflow_feature_t f);
		@(posedge clk);
		cur_x <= f.x;
		cur_y <= f.y;
		cur_w <= f.w;
		cur_h <= f.h;
		model_cur = f;
	endtask

	// wr_en stays high until the run task drops it
	task automatic write_slot(input int addr, input int id, input oflow_feature_t f);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_addr <= ADDR_W'(addr);
		wr_id <= ID_LEN'(id);
		wr_x <= f.x;
		wr_y <= f.y;
		wr_w <= f.w;
		wr_h <= f.h;
		model_id[addr] = id;
		model_feat[addr] = f;
	endtask

	// one start, optional extra starts at run cycles 2, 5 and 8
	task automatic run_and_check(input string name, input bit extra_starts);
		int n;
		bit seen;
		test_name = name;
		compute_expected();
		@(posedge clk);
		wr_en <= 1'b0;
		start_score_calc <= 1'b1;
		n = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT) begin
			@(posedge clk);
			n++;
			start_score_calc <= extra_starts && (n == 2 || n == 5 || n == 8);
			if (result_valid) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			report_error("no result_valid within the timeout");
		end
		// room for a stray second strobe
		repeat (LATENCY) @(posedge clk);
	endtask

	// slots a and b identical and nearest among far slots
	task automatic run_tie(input string name, input int a, input int b);
		oflow_feature_t c;
		oflow_feature_t near;
		c = '{x: 8'd100, y: 8'd90, w: 8'd80, h: 8'd70};
		near = c;
		near.x = c.x + 8'd3;
		set_current(c);
		for (int i = 0; i < NUM_OBJ; i++) begin
			write_slot(i, i + 1, (i == a || i == b) ? near : far_feat(c));
		end
		run_and_check(name, 1'b0);
		// lower slot keeps the tie
		tie_winner: assert (best_id == ID_LEN'(a + 1))
			else report_mismatch("tie_slot_id", a + 1, best_id);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		oflow_feature_t c;
		void'($urandom(72555));
		clk = 1'b0;
		reset_N = 1'b0;
		start_score_calc = 1'b0;
		cur_x = '0;
		cur_y = '0;
		cur_w = '0;
		cur_h = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_id = '0;
		wr_x = '0;
		wr_y = '0;
		wr_w = '0;
		wr_h = '0;
		test_name = "reset";
		repeat (10) @(posedge clk);
		reset_N <= 1'b1;

		// quiet after reset, no start yet
		test_name = "idle_after_reset";
		repeat (20) @(posedge clk);

		for (int r = 0; r < 20; r++) begin
			set_current(rand_feat());
			for (int i = 0; i < NUM_OBJ; i++) begin
				write_slot(i, $urandom_range(1, 15), rand_feat());
			end
			run_and_check("random_full", 1'b0);
		end

		// empty odd slots hold an exact match of the current object
		for (int r = 0; r < 4; r++) begin
			c = rand_feat();
			set_current(c);
			for (int i = 0; i < NUM_OBJ; i++) begin
				if (i % 2 == 1) begin
					write_slot(i, 0, c);
				end else begin
					write_slot(i, $urandom_range(1, 15), rand_feat());
				end
			end
			run_and_check("odd_slots_empty", 1'b0);
		end

		run_tie("tie_across_pairs", 1, 6);
		run_tie("tie_same_pair", 4, 5);

		set_current(rand_feat());
		for (int i = 0; i < NUM_OBJ; i++) begin
			write_slot(i, 0, rand_feat());
		end
		run_and_check("empty_table", 1'b0);

		for (int r = 0; r < 3; r++) begin
			set_current(rand_feat());
			for (int i = 0; i < NUM_OBJ; i++) begin
				write_slot(i, $urandom_range(1, 15), rand_feat());
			end
			run_and_check("extra_starts", 1'b1);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- vlog.f
design/oflow_pkg.sv
design/oflow_sm_if.sv
design/oflow_score_buffer.sv
design/oflow_score_calc_fsm.sv
design/oflow_similarity_metric.sv
design/oflow_score_select.sv
design/oflow_score_calc_top.sv
verif/oflow_score_calc_tb.sv
